//--- bench/dac_subsystem_asserts.sv
`timescale 1ns/10ps

module dac_subsystem_asserts (
	input logic clk_in,
	input logic reset_in,
	input logic nsync_out,
	input logic sclk_out,
	input logic din_out,
	input logic frame_done
);

	////////////////////////////////////////////////////////////
	// serial pin rules
	////////////////////////////////////////////////////////////

	// clock parked low outside the sync window
	sclk_idle_low: assert property (@(posedge clk_in) disable iff (reset_in)
		nsync_out |-> !sclk_out)
		else $error("sclk_out high while nsync_out is high");

	// one-cycle done exactly at each nsync rise
	done_at_rise: assert property (@(posedge clk_in) disable iff (reset_in)
		frame_done == $rose(nsync_out))
		else $error("frame_done does not line up with the nsync_out rise");

	// din held through the high half, dac samples on the fall
	din_stable_high: assert property (@(posedge clk_in) disable iff (reset_in)
		$past(sclk_out) |-> $stable(din_out))
		else $error("din_out moved while sclk_out was high");

endmodule

bind serial_shifter dac_subsystem_asserts shifter_asserts_inst (.*);

//--- bench/dac_subsystem_tb.sv
`timescale 1ns/10ps

module dac_subsystem_tb;

	import dac_pkg::*;

	localparam int HALF_PERIOD    = 5;
	localparam int FRAME_CYCLES   = 70;                        // 65 low + gap, rounded up
	localparam int TIMEOUT_CYCLES = 40 * FRAME_CYCLES + 1200;  // ~40 frames plus margin

	logic              clk_in;
	logic              reset_in;
	logic              wr_in;
	logic [CH_W-1:0]   wr_channel_in;
	logic [DATA_W-1:0] wr_data_in;
	logic              ref_set_in;
	logic              nsync_out;
	logic              sclk_out;
	logic              din_out;
	logic              frame_done_out;

	logic [DATA_W-1:0] model_val [N_CHAN];   // last value written per channel
	logic [31:0]       rng_state;
	int                cycle_cnt;
	int                err_cnt;
	int                tests_run;
	int                tests_failed;

	// frame capture
	dac_instr_u  frames [$];                 // decoded words in arrival order
	int          rises [$];                  // sclk rises seen in each frame
	logic [31:0] shift_word;
	logic        prev_sclk;
	logic        prev_nsync;
	int          rise_cnt;
	int          done_cnt;

	dac_subsystem dac_subsystem_inst (.*);

	always #HALF_PERIOD clk_in = ~clk_in;

	// watchdog
	always @(posedge clk_in) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: run stopped after %0d cycles", cycle_cnt);
			$display("Regression failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// monitor, samples mid-cycle where pins are stable
	////////////////////////////////////////////////////////////

	always @(negedge clk_in) begin
		if (reset_in) begin
			prev_sclk  = 1'b0;
			prev_nsync = 1'b1;
			rise_cnt   = 0;
		end else begin
			if (!nsync_out && sclk_out && !prev_sclk) begin
				rise_cnt++;
			end
			if (!nsync_out && !sclk_out && prev_sclk) begin
				shift_word = {shift_word[30:0], din_out};   // msb arrives first
			end
			if (nsync_out && !prev_nsync) begin
				frames.push_back(shift_word);               // frame closed
				rises.push_back(rise_cnt);
				rise_cnt = 0;
			end
			if (frame_done_out) begin
				done_cnt++;
			end
			prev_sclk  = sclk_out;
			prev_nsync = nsync_out;
		end
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [DATA_W-1:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state[DATA_W-1:0];
	endfunction

	task automatic report_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		$display("FAIL t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, act);
		err_cnt++;
	endtask

	task automatic report_problem(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		err_cnt++;
	endtask

	// entered and left on a falling edge
	task automatic write_channel(input logic [CH_W-1:0] ch, input logic [DATA_W-1:0] val);
		wr_in         = 1'b1;
		wr_channel_in = ch;
		wr_data_in    = val;
		model_val[ch] = val;
		@(negedge clk_in);
		wr_in = 1'b0;
	endtask

	task automatic request_ref();
		ref_set_in = 1'b1;
		@(negedge clk_in);
		ref_set_in = 1'b0;
	endtask

	// wait for n new frames, then make sure no extra one follows
	task automatic collect_frames(input int base, input int n, output logic ok);
		int waited;
		waited = 0;
		while (frames.size() < base + n && waited < n * FRAME_CYCLES + 40) begin
			@(negedge clk_in);
			waited++;
		end
		repeat (FRAME_CYCLES + 10) @(negedge clk_in);
		ok = (frames.size() == base + n);
		if (!ok) begin
			report_problem($sformatf("expected %0d frames but %0d arrived", n,
				frames.size() - base));
		end
	endtask

	// write frames, any order, each channel of the mask exactly once
	task automatic check_write_frames(input int first, input int count,
			input logic [N_CHAN-1:0] expect_mask);
		logic [N_CHAN-1:0] seen;
		dac_instr_u        f;
		int                ch;
		seen = '0;
		for (int i = 0; i < count; i++) begin
			f  = frames[first + i];
			ch = f.write_view.address[CH_W-1:0];
			if (f.write_view.prefix !== DAC_PREFIX)
				report_value("write_view.prefix", DAC_PREFIX, f.write_view.prefix);
			if (f.write_view.control !== CTRL_WRITE_UPDATE)
				report_value("write_view.control", CTRL_WRITE_UPDATE, f.write_view.control);
			if (f.write_view.feature !== FEATURE_NONE)
				report_value("write_view.feature", FEATURE_NONE, f.write_view.feature);
			if (rises[first + i] != FRAME_BITS)
				report_value("sclk_out rises", FRAME_BITS, rises[first + i]);
			if (f.write_view.address[ADDR_W-1] || !expect_mask[ch] || seen[ch]) begin
				report_problem($sformatf("frame %0d goes to channel %0d, unexpected or repeated",
					first + i, f.write_view.address));
			end else begin
				seen[ch] = 1'b1;
				if (f.write_view.data !== model_val[ch])
					report_value($sformatf("write_view.data ch%0d", ch), model_val[ch],
						f.write_view.data);
			end
		end
		if (seen !== expect_mask)
			report_problem($sformatf("no frame for channels in mask 0x%0h", expect_mask & ~seen));
	endtask

	task automatic check_ref_frame(input int idx);
		dac_instr_u f;
		f = frames[idx];
		if (f.ref_view.prefix !== DAC_PREFIX)
			report_value("ref_view.prefix", DAC_PREFIX, f.ref_view.prefix);
		if (f.ref_view.control !== CTRL_REF_SETUP)
			report_value("ref_view.control", CTRL_REF_SETUP, f.ref_view.control);
		if (f.ref_view.reserved !== 4'b0000)
			report_value("ref_view.reserved", 0, f.ref_view.reserved);
		if (f.ref_view.ref_mode !== REF_ALWAYS_ON)
			report_value("ref_view.ref_mode", REF_ALWAYS_ON, f.ref_view.ref_mode);
		if (rises[idx] != FRAME_BITS)
			report_value("sclk_out rises", FRAME_BITS, rises[idx]);
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (err_cnt == errs_before) begin
			$display("%-18s ok", name);
		end else begin
			tests_failed++;
			$display("%-18s failed with %0d errors", name, err_cnt - errs_before);
		end
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task automatic idle_after_reset();
		int errs;
		errs = err_cnt;
		repeat (20) begin
			if (nsync_out !== 1'b1) report_value("nsync_out", 1, nsync_out);
			if (sclk_out !== 1'b0) report_value("sclk_out", 0, sclk_out);
			if (din_out !== 1'b0) report_value("din_out", 0, din_out);
			if (frame_done_out !== 1'b0) report_value("frame_done_out", 0, frame_done_out);
			@(negedge clk_in);
		end
		if (frames.size() != 0) report_problem("a frame was sent with no request");
		finish_test("idle_after_reset", errs);
	endtask

	task automatic single_write();
		int   errs;
		int   base;
		int   done_base;
		logic ok;
		errs      = err_cnt;
		base      = frames.size();
		done_base = done_cnt;
		write_channel(3'd5, next_rand());
		collect_frames(base, 1, ok);
		if (ok) check_write_frames(base, 1, 8'h20);
		if (done_cnt - done_base != 1)
			report_value("frame_done_out pulses", 1, done_cnt - done_base);
		finish_test("single_write", errs);
	endtask

	task automatic reference_setup();
		int   errs;
		int   base;
		logic ok;
		errs = err_cnt;
		base = frames.size();
		request_ref();
		collect_frames(base, 1, ok);
		if (ok) check_ref_frame(base);
		// ref raised behind two dirty channels during a frame
		base = frames.size();
		write_channel(3'd1, next_rand());
		write_channel(3'd2, next_rand());
		write_channel(3'd3, next_rand());
		request_ref();
		collect_frames(base, 4, ok);
		if (ok) begin
			check_write_frames(base, 1, 8'h02);
			check_ref_frame(base + 1);               // ref jumps the queue
			check_write_frames(base + 2, 2, 8'h0c);
		end
		finish_test("reference_setup", errs);
	endtask

	task automatic channel_sweep();
		int   errs;
		int   base;
		logic ok;
		errs = err_cnt;
		base = frames.size();
		for (int ch = 0; ch < N_CHAN; ch++) begin
			write_channel(CH_W'(ch), next_rand());   // back to back
		end
		collect_frames(base, N_CHAN, ok);
		if (ok) check_write_frames(base, N_CHAN, 8'hff);
		finish_test("channel_sweep", errs);
	endtask

	task automatic write_coalescing();
		int   errs;
		int   base;
		logic ok;
		errs = err_cnt;
		base = frames.size();
		write_channel(3'd4, next_rand());            // starts a frame
		write_channel(3'd6, next_rand());            // dirty behind it
		repeat (4) begin
			repeat (8) @(negedge clk_in);
			write_channel(3'd6, next_rand());        // overwrite, still in flight
		end
		write_channel(3'd1, next_rand());
		collect_frames(base, 3, ok);                 // three distinct channels
		if (ok) check_write_frames(base, 3, 8'h52);
		finish_test("write_coalescing", errs);
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		clk_in        = 1'b0;
		reset_in      = 1'b1;
		wr_in         = 1'b0;
		wr_channel_in = '0;
		wr_data_in    = '0;
		ref_set_in    = 1'b0;
		rng_state     = 32'd13174;
		cycle_cnt     = 0;
		err_cnt       = 0;
		tests_run     = 0;
		tests_failed  = 0;
		done_cnt      = 0;
		shift_word    = '0;
		for (int i = 0; i < N_CHAN; i++) begin
			model_val[i] = '0;                       // table is zero after reset
		end
		repeat (4) @(posedge clk_in);
		@(negedge clk_in);
		reset_in = 1'b0;

		idle_after_reset();
		single_write();
		reference_setup();
		channel_sweep();
		write_coalescing();

		$display("tests %0d, failed %0d, check errors %0d", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- hdl/channel_sequencer.sv
`timescale 1ns/10ps

module channel_sequencer (
	input  logic                       clk_in,
	input  logic                       reset_in,
	input  logic                       wr_in,          // one-cycle write strobe
	input  logic [dac_pkg::CH_W-1:0]   wr_channel_in,
	input  logic [dac_pkg::DATA_W-1:0] wr_data_in,
	input  logic                       ref_set_in,     // request ref setup
	input  logic                       frame_done,     // from shifter
	output dac_pkg::dac_req_t          req,
	output logic                       req_valid
);

	import dac_pkg::*;

	////////////////////////////////////////////////////////////
	// state
	////////////////////////////////////////////////////////////

	logic [DATA_W-1:0] setpoint [N_CHAN];   // latest value per channel
	logic [N_CHAN-1:0] dirty;               // channel waiting to be sent
	logic              ref_pend;            // ref setup waiting
	logic              in_flight;           // one frame at a time
	logic [CH_W-1:0]   ptr;                 // round-robin start point

	// pick logic
	logic [CH_W-1:0]   cand;
	logic [CH_W-1:0]   pick_ch;
	logic              pick_found;
	logic              issue_ref;
	logic              issue_ch;

	////////////////////////////////////////////////////////////
	// round-robin pick
	////////////////////////////////////////////////////////////

	// first dirty channel at or after ptr, index wraps mod 8
	always_comb begin
		pick_found = 1'b0;
		pick_ch    = ptr;
		cand       = ptr;
		for (int i = 0; i < N_CHAN; i++) begin
			cand = ptr + CH_W'(i);
			if (!pick_found && dirty[cand]) begin
				pick_found = 1'b1;
				pick_ch    = cand;
			end
		end
	end

	assign issue_ref = !in_flight && ref_pend;                 // ref has priority
	assign issue_ch  = !in_flight && !ref_pend && pick_found;

	////////////////////////////////////////////////////////////
	// table and flags
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			for (int i = 0; i < N_CHAN; i++) begin
				setpoint[i] <= '0;
			end
		end else if (wr_in) begin
			setpoint[wr_channel_in] <= wr_data_in;    // newest value wins
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			dirty     <= '0;
			ref_pend  <= 1'b0;
			in_flight <= 1'b0;
			ptr       <= '0;
			req_valid <= 1'b0;
		end else begin
			// clear on issue first, a same-cycle write sets it again
			if (issue_ch) begin
				dirty[pick_ch] <= 1'b0;
				if (wr_in) begin
					dirty[wr_channel_in] <= 1'b1;
				end
			end else if (wr_in) begin
				dirty[wr_channel_in] <= 1'b1;
			end

			if (ref_set_in) begin
				ref_pend <= 1'b1;
			end else if (issue_ref) begin
				ref_pend <= 1'b0;
			end

			if (issue_ref || issue_ch) begin
				in_flight <= 1'b1;
			end else if (frame_done) begin
				in_flight <= 1'b0;                    // shifter free again
			end

			if (issue_ch) begin
				ptr <= pick_ch + 1'b1;                // skip past the one just sent
			end

			req_valid <= issue_ref || issue_ch;
		end
	end

	// request payload, only looked at with req_valid
	always_ff @(posedge clk_in) begin
		if (issue_ref) begin
			req.is_ref  <= 1'b1;
			req.channel <= '0;
			req.data    <= '0;
		end else if (issue_ch) begin
			req.is_ref  <= 1'b0;
			req.channel <= pick_ch;
			req.data    <= setpoint[pick_ch];     // value before any same-cycle write
		end
	end

endmodule

//--- hdl/dac_pkg.sv
package dac_pkg;

	////////////////////////////////////////////////////////////
	// chip geometry
	////////////////////////////////////////////////////////////

	localparam int N_CHAN     = 8;                    // dac channels on the chip
	localparam int CH_W       = 3;                    // channel index width
	localparam int DATA_W     = 16;                   // setpoint width
	localparam int FRAME_BITS = 32;                   // bits per serial instruction
	localparam int ADDR_W     = 4;                    // address field, msb is broadcast
	localparam int BIT_CNT_W  = $clog2(FRAME_BITS);   // shifter bit counter

	////////////////////////////////////////////////////////////
	// instruction field codes
	////////////////////////////////////////////////////////////

	localparam logic [3:0] DAC_PREFIX        = 4'b0000;
	localparam logic [3:0] CTRL_WRITE_UPDATE = 4'b0011; // write selected reg and update
	localparam logic [3:0] CTRL_REF_SETUP    = 4'b1001; // internal reference setup
	localparam logic [3:0] REF_ALWAYS_ON     = 4'b1010; // reference mode, always on
	localparam logic [3:0] FEATURE_NONE      = 4'b0000;

	// shifter fsm codes
	localparam int         ST_W     = 2;
	localparam logic [1:0] ST_IDLE  = 2'd0;           // wait for a word
	localparam logic [1:0] ST_SETUP = 2'd1;           // nsync low, sclk held low
	localparam logic [1:0] ST_SHIFT = 2'd2;           // 32 bit periods
	localparam logic [1:0] ST_DONE  = 2'd3;           // one cycle after nsync rises

	////////////////////////////////////////////////////////////
	// types
	////////////////////////////////////////////////////////////

	// one update request, sequencer to encoder
	typedef struct packed {
		logic              is_ref;                    // reference setup, channel/data ignored
		logic [CH_W-1:0]   channel;
		logic [DATA_W-1:0] data;
	} dac_req_t;

	// write to channel register and update
	typedef struct packed {
		logic [3:0]        prefix;
		logic [3:0]        control;
		logic [ADDR_W-1:0] address;
		logic [DATA_W-1:0] data;
		logic [3:0]        feature;
	} dac_write_t;

	// internal reference setup
	typedef struct packed {
		logic [3:0]  prefix;
		logic [3:0]  control;
		logic [3:0]  reserved;
		logic [3:0]  ref_mode;
		logic [15:0] unused;                          // don't care low half
	} dac_ref_t;

	// one 32-bit instruction, two ways to read it
	typedef union packed {
		dac_write_t write_view;
		dac_ref_t   ref_view;
	} dac_instr_u;

endpackage

//--- hdl/dac_subsystem.sv
`timescale 1ns/10ps

module dac_subsystem (
	input  logic                       clk_in,
	input  logic                       reset_in,
	input  logic                       wr_in,
	input  logic [dac_pkg::CH_W-1:0]   wr_channel_in,
	input  logic [dac_pkg::DATA_W-1:0] wr_data_in,
	input  logic                       ref_set_in,
	output logic                       nsync_out,
	output logic                       sclk_out,
	output logic                       din_out,
	output logic                       frame_done_out
);

	import dac_pkg::*;

	////////////////////////////////////////////////////////////
	// stage links
	////////////////////////////////////////////////////////////

	dac_req_t   req;            // sequencer -> encoder
	logic       req_valid;
	dac_instr_u instr;          // encoder -> shifter
	logic       instr_valid;

	// picks the next update, waits for frame_done
	channel_sequencer channel_sequencer_inst (
		.clk_in        (clk_in),
		.reset_in      (reset_in),
		.wr_in         (wr_in),
		.wr_channel_in (wr_channel_in),
		.wr_data_in    (wr_data_in),
		.ref_set_in    (ref_set_in),
		.frame_done    (frame_done_out),
		.req           (req),
		.req_valid     (req_valid)
	);

	instr_encoder instr_encoder_inst (
		.clk_in      (clk_in),
		.reset_in    (reset_in),
		.req         (req),
		.req_valid   (req_valid),
		.instr       (instr),
		.instr_valid (instr_valid)
	);

	// pins straight off registers
	serial_shifter serial_shifter_inst (
		.clk_in      (clk_in),
		.reset_in    (reset_in),
		.instr       (instr),
		.instr_valid (instr_valid),
		.nsync_out   (nsync_out),
		.sclk_out    (sclk_out),
		.din_out     (din_out),
		.frame_done  (frame_done_out)
	);

endmodule

//--- hdl/instr_encoder.sv
`timescale 1ns/10ps

module instr_encoder (
	input  logic                clk_in,
	input  logic                reset_in,
	input  dac_pkg::dac_req_t   req,
	input  logic                req_valid,
	output dac_pkg::dac_instr_u instr,
	output logic                instr_valid
);

	import dac_pkg::*;

	////////////////////////////////////////////////////////////
	// word build
	////////////////////////////////////////////////////////////

	dac_instr_u instr_next;

	always_comb begin
		instr_next = '0;
		if (req.is_ref) begin
			// reference view, low half left zero
			instr_next.ref_view.prefix   = DAC_PREFIX;
			instr_next.ref_view.control  = CTRL_REF_SETUP;
			instr_next.ref_view.reserved = 4'b0000;
			instr_next.ref_view.ref_mode = REF_ALWAYS_ON;
		end else begin
			instr_next.write_view.prefix  = DAC_PREFIX;
			instr_next.write_view.control = CTRL_WRITE_UPDATE;
			instr_next.write_view.address = {1'b0, req.channel}; // no broadcast
			instr_next.write_view.data    = req.data;
			instr_next.write_view.feature = FEATURE_NONE;
		end
	end

	////////////////////////////////////////////////////////////
	// pipeline register
	////////////////////////////////////////////////////////////

	// word itself has no reset, qualified by instr_valid
	always_ff @(posedge clk_in) begin
		if (req_valid) begin
			instr <= instr_next;
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			instr_valid <= 1'b0;
		end else begin
			instr_valid <= req_valid;     // one cycle behind the request
		end
	end

endmodule

//--- hdl/serial_shifter.sv
`timescale 1ns/10ps

module serial_shifter (
	input  logic                clk_in,
	input  logic                reset_in,
	input  dac_pkg::dac_instr_u instr,
	input  logic                instr_valid,    // one-cycle load strobe
	output logic                nsync_out,      // frame window, active low
	output logic                sclk_out,       // half clk rate during shift
	output logic                din_out,        // msb first
	output logic                frame_done      // pulse as nsync rises
);

	import dac_pkg::*;

	localparam logic [BIT_CNT_W-1:0] LAST_BIT = BIT_CNT_W'(FRAME_BITS - 1);

	////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////

	logic [ST_W-1:0]       state;
	logic [FRAME_BITS-1:0] shreg;       // word being sent
	logic                  phase;       // high half of a bit period
	logic [BIT_CNT_W-1:0]  bit_cnt;     // current bit period
	logic                  load;
	logic                  advance;     // end of a low half, next bit goes out

	assign load    = (state == ST_IDLE) && instr_valid;
	assign advance = (state == ST_SHIFT) && !phase && (bit_cnt != LAST_BIT);

	// shift register, payload only
	always_ff @(posedge clk_in) begin
		if (load) begin
			shreg <= instr;
		end else if (advance) begin
			shreg <= shreg << 1;
		end
	end

	////////////////////////////////////////////////////////////
	// frame fsm
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state      <= ST_IDLE;
			nsync_out  <= 1'b1;
			sclk_out   <= 1'b0;
			din_out    <= 1'b0;
			frame_done <= 1'b0;
			phase      <= 1'b0;
			bit_cnt    <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (instr_valid) begin
						nsync_out <= 1'b0;                  // open sync window
						din_out   <= instr[FRAME_BITS-1];   // bit 31 ready before first rise
						state     <= ST_SETUP;
					end
				end
				ST_SETUP: begin
					sclk_out <= 1'b1;                       // first period starts
					phase    <= 1'b1;
					bit_cnt  <= '0;
					state    <= ST_SHIFT;
				end
				ST_SHIFT: begin
					if (phase) begin
						sclk_out <= 1'b0;                   // dac samples here
						phase    <= 1'b0;
					end else if (bit_cnt == LAST_BIT) begin
						nsync_out  <= 1'b1;                 // 32 periods done
						frame_done <= 1'b1;
						state      <= ST_DONE;
					end else begin
						// din moves together with the sclk rise
						sclk_out <= 1'b1;
						phase    <= 1'b1;
						din_out  <= shreg[FRAME_BITS-2];
						bit_cnt  <= bit_cnt + 1'b1;
					end
				end
				ST_DONE: begin
					frame_done <= 1'b0;
					din_out    <= 1'b0;                     // park low between frames
					state      <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

//--- verilog.f
hdl/dac_pkg.sv
hdl/channel_sequencer.sv
hdl/instr_encoder.sv
hdl/serial_shifter.sv
hdl/dac_subsystem.sv
bench/dac_subsystem_asserts.sv
bench/dac_subsystem_tb.sv
